/* Bender.yml */
package:
  name: rvseed

export_include_dirs:
  - src

sources:
  - files:
      - src/rvseed_pkg.sv
      - src/ctrl.sv
      - src/imm_gen.sv
      - src/regfile.sv
      - src/exec_unit.sv
      - src/fetch_wb.sv
      - src/rvseed_core.sv
  - target: test
    files:
      - testbench/rvseed_sva.sv
      - testbench/tb_rvseed.sv

/* src/ctrl.sv */
`include "rvseed_config.svh"

module ctrl import rvseed_pkg::*; (
    input  inst_t inst,
    output ctrl_t ctl
);

    always_comb begin
        ctl         = '0;
        ctl.imm_op  = IMM_I;
        ctl.alu_op  = ALU_ADD;
        ctl.alu_src = SRC_REG;

        case (inst.r_fmt.opcode)
            OP_R: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = inst.r_fmt.rd;
                ctl.rs1     = inst.r_fmt.rs1;
                ctl.rs2     = inst.r_fmt.rs2;
                if (inst.r_fmt.funct3 == F3_ADD && inst.r_fmt.funct7 == F7_BASE) begin
                    ctl.alu_op = ALU_ADD;
                end else if (inst.r_fmt.funct3 == F3_ADD && inst.r_fmt.funct7 == F7_ALT) begin
                    ctl.alu_op = ALU_SUB;
                end else begin
                    ctl.illegal = 1'b1;          // and, or, shifts, slt ...
                end
            end
            OP_I: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = inst.i_fmt.rd;
                ctl.rs1     = inst.i_fmt.rs1;
                ctl.alu_src = SRC_IMM;
                if (inst.i_fmt.funct3 != F3_ADD) begin
                    ctl.illegal = 1'b1;          // only addi
                end
            end
            OP_B: begin
                ctl.rs1    = inst.b_fmt.rs1;
                ctl.rs2    = inst.b_fmt.rs2;
                ctl.imm_op = IMM_B;
                ctl.alu_op = ALU_SUB;            // difference drives the compare
                if (inst.b_fmt.funct3 == F3_BNE) begin
                    ctl.branch = 1'b1;
                end else begin
                    ctl.illegal = 1'b1;
                end
            end
            OP_JAL: begin
                ctl.jump    = 1'b1;
                ctl.reg_wen = 1'b1;
                ctl.rd      = inst.j_fmt.rd;
                ctl.imm_op  = IMM_J;
                ctl.alu_src = SRC_FOUR_PC;       // link value
            end
            OP_JALR: begin
                ctl.rd      = inst.i_fmt.rd;
                ctl.rs1     = inst.i_fmt.rs1;
                ctl.alu_src = SRC_FOUR_PC;
                if (inst.i_fmt.funct3 == F3_ADD) begin
                    ctl.jump    = 1'b1;
                    ctl.jalr    = 1'b1;
                    ctl.reg_wen = 1'b1;
                end else begin
                    ctl.illegal = 1'b1;
                end
            end
            OP_LUI: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = inst.u_fmt.rd;
                ctl.imm_op  = IMM_U;
                ctl.alu_src = SRC_IMM;           // x0 + imm
            end
            OP_AUIPC: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = inst.u_fmt.rd;
                ctl.imm_op  = IMM_U;
                ctl.alu_src = SRC_IMM_PC;
            end
            OP_SYSTEM: begin
                if (inst.word == `RVSEED_EBREAK_WORD) begin
                    ctl.ebreak = 1'b1;
                end else begin
                    ctl.illegal = 1'b1;          // ecall, csr access
                end
            end
            default: begin
                ctl.illegal = 1'b1;              // loads, stores, fence ...
            end
        endcase

        // a trapping word never writes back
        if (ctl.illegal) begin
            ctl.reg_wen = 1'b0;
            ctl.jump    = 1'b0;
            ctl.jalr    = 1'b0;
            ctl.branch  = 1'b0;
        end
    end

endmodule

/* src/exec_unit.sv */
module exec_unit import rvseed_pkg::*; (
    input  ctrl_t       ctl,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] imm,
    output logic [31:0] wdata,
    output logic [31:0] next_pc
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;
    logic [31:0] jalr_sum;
    logic        taken;

    always_comb begin
        case (ctl.alu_src)
            SRC_REG: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            SRC_IMM: begin
                op_a = rs1_data;
                op_b = imm;
            end
            SRC_IMM_PC: begin
                op_a = pc;
                op_b = imm;
            end
            default: begin                       // SRC_FOUR_PC
                op_a = pc;
                op_b = 32'd4;
            end
        endcase
    end

    assign result = (ctl.alu_op == ALU_SUB) ? op_a - op_b : op_a + op_b;
    assign wdata  = result;

    // bne: operands differ when the difference is nonzero
    assign taken    = ctl.branch && (result != 32'd0);
    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (ctl.jalr) begin
            next_pc = {jalr_sum[31:1], 1'b0};
        end else if (ctl.jump || taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

endmodule

/* src/fetch_wb.sv */
`include "rvseed_config.svh"

module fetch_wb import rvseed_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] next_pc,
    input  logic        stop,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_i,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [31:0] wb_adr,
    output logic        wb_we,
    output logic [3:0]  wb_sel,
    output logic [31:0] pc,
    output inst_t       inst,
    output logic        fire
);

    typedef enum logic [1:0] {
        ST_IDLE,                                 // gap between two fetches
        ST_REQ,                                  // cycle open, waiting for ack
        ST_HALTED
    } fetch_state_t;

    fetch_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            pc    <= `RVSEED_RESET_PC;
        end else begin
            case (state)
                ST_IDLE: begin
                    state <= ST_REQ;
                end
                ST_REQ: begin
                    if (wb_ack) begin
                        pc    <= next_pc;
                        state <= stop ? ST_HALTED : ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_HALTED;          // only reset leaves here
                end
            endcase
        end
    end

    assign fire   = (state == ST_REQ) && wb_ack;
    assign wb_cyc = (state == ST_REQ);
    assign wb_stb = (state == ST_REQ);
    assign wb_adr = pc;
    assign wb_we  = 1'b0;                        // fetch only
    assign wb_sel = 4'hf;
    assign inst   = inst_t'(wb_dat_i);

endmodule

/* src/imm_gen.sv */
module imm_gen import rvseed_pkg::*; (
    input  inst_t       inst,
    input  imm_op_t     imm_op,
    output logic [31:0] imm
);

    always_comb begin
        case (imm_op)
            IMM_I: begin
                imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            IMM_B: begin
                imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                       inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
            end
            IMM_J: begin
                imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                       inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
            end
            IMM_U: begin
                imm = {inst.u_fmt.imm31_12, 12'b0};   // lower bits always zero
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* src/regfile.sv */
`include "rvseed_config.svh"

module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [`RVSEED_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RVSEED_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;                // x0 stays zero
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

/* src/rvseed_config.svh */
`ifndef RVSEED_CONFIG_SVH
`define RVSEED_CONFIG_SVH

// first fetch address once reset is released
`define RVSEED_RESET_PC 32'h0000_0000

// architectural register count, x0 included
`define RVSEED_NUM_REGS 32

// the one SYSTEM encoding the core accepts
`define RVSEED_EBREAK_WORD 32'h0010_0073

`endif

/* src/rvseed_core.sv */
module rvseed_core import rvseed_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_i,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [31:0] wb_adr,
    output logic        wb_we,
    output logic [3:0]  wb_sel,
    output retire_t     retire,
    output logic        halt,
    output logic        illegal
);

    inst_t       inst;
    ctrl_t       ctl;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] wdata;
    logic        fire;
    logic        stop;

    assign stop = ctl.ebreak || ctl.illegal;

    fetch_wb i_fetch (
        .clk      (clk),
        .reset    (reset),
        .next_pc  (next_pc),
        .stop     (stop),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .pc       (pc),
        .inst     (inst),
        .fire     (fire)
    );

    ctrl i_ctrl (
        .inst (inst),
        .ctl  (ctl)
    );

    imm_gen i_imm_gen (
        .inst   (inst),
        .imm_op (ctl.imm_op),
        .imm    (imm)
    );

    regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (fire && ctl.reg_wen),           // commit only on ack
        .waddr  (ctl.rd),
        .wdata  (wdata),
        .raddr1 (ctl.rs1),
        .raddr2 (ctl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit i_exec (
        .ctl      (ctl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .wdata    (wdata),
        .next_pc  (next_pc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
            halt         <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire.valid <= fire;                // one cycle per retired word
            if (fire && stop) begin
                halt <= 1'b1;                    // sticky until reset
            end
            if (fire && ctl.illegal) begin
                illegal <= 1'b1;
            end
        end
    end

    // trace payload, meaningful only while valid
    always_ff @(posedge clk) begin
        if (fire) begin
            retire.pc    <= pc;
            retire.rd    <= ctl.rd;
            retire.wen   <= ctl.reg_wen;
            retire.wdata <= wdata;
        end
    end

endmodule

/* src/rvseed_pkg.sv */
package rvseed_pkg;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_B      = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        F3_ADD = 3'b000,              // add, sub, addi and jalr
        F3_BNE = 3'b001
    } funct3_t;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000          // selects sub
    } funct7_t;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_REG     = 2'd0,           // rs1, rs2
        SRC_IMM     = 2'd1,           // rs1, imm
        SRC_IMM_PC  = 2'd2,           // pc, imm
        SRC_FOUR_PC = 2'd3            // pc, 4
    } alu_src_t;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_B = 2'd1,
        IMM_J = 2'd2,
        IMM_U = 2'd3
    } imm_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    // one fetched word, viewed in every supported format
    typedef union packed {
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        b_fmt_t      b_fmt;
        j_fmt_t      j_fmt;
        u_fmt_t      u_fmt;
        logic [31:0] word;
    } inst_t;

    typedef struct packed {
        logic     branch;
        logic     jump;
        logic     jalr;
        logic     reg_wen;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        imm_op_t  imm_op;
        alu_op_t  alu_op;
        alu_src_t alu_src;
        logic     ebreak;
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] wdata;
    } retire_t;

endpackage

/* testbench/rvseed_sva.sv */
module rvseed_sva (
    input logic        clk,
    input logic        reset,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic [31:0] wb_adr,
    input logic        wb_ack,
    input logic        halt,
    input logic        retire_valid
);

    int fail_count = 0;                          // failed assertions so far

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            fail_count++;
        end

    // slave has not answered, request must hold
    adr_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else begin
            $error("wb_adr or wb_stb changed before wb_ack");
            fail_count++;
        end

    no_fetch_halted: assert property (@(posedge clk) disable iff (reset)
        halt |-> !wb_stb)
        else begin
            $error("wb_stb high while halted");
            fail_count++;
        end

    retire_after_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && wb_ack) |=> retire_valid)
        else begin
            $error("no retire record one cycle after wb_ack");
            fail_count++;
        end

    retire_only_after_ack: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(wb_stb && wb_ack))
        else begin
            $error("retire record without a preceding wb_ack");
            fail_count++;
        end

endmodule

/* testbench/tb_rvseed.sv */
`include "rvseed_config.svh"

module tb_rvseed import rvseed_pkg::*; ;

    logic        clk;
    logic        reset;
    logic        wb_ack;
    logic [31:0] wb_dat_i;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic        wb_we;
    logic [3:0]  wb_sel;
    retire_t     retire;
    logic        halt;
    logic        illegal;

    logic [31:0] mem [256];                     // program image, word addressed
    logic [31:0] model_regs [`RVSEED_NUM_REGS];
    logic [31:0] model_pc;
    logic        model_halted;
    logic        model_illegal;
    int          retired;
    logic [31:0] lfsr_state;
    string       run_name;
    int          wait_left;
    logic        serving;
    retire_t     expected_rec;

    rvseed_core i_dut (
        .clk      (clk),
        .reset    (reset),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .retire   (retire),
        .halt     (halt),
        .illegal  (illegal)
    );

    bind rvseed_core rvseed_sva i_sva (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .halt         (halt),
        .retire_valid (retire.valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] btype_word(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // instruction-set reference, one instruction per call
    function automatic retire_t model_step(input logic [31:0] w);
        retire_t     r;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] next;
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        next  = model_pc + 32'd4;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = model_pc;
        r.rd    = rd;
        if (w == `RVSEED_EBREAK_WORD) begin
            model_halted = 1'b1;
        end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'd0 && w[31:25] == 7'h00) begin
            r.wen   = 1'b1;
            r.wdata = a + b;
        end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'd0 && w[31:25] == 7'h20) begin
            r.wen   = 1'b1;
            r.wdata = a - b;
        end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'd0) begin
            r.wen   = 1'b1;
            r.wdata = a + imm_i;
        end else if (w[6:0] == 7'b1100011 && w[14:12] == 3'd1) begin
            if (a != b) begin
                next = model_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
        end else if (w[6:0] == 7'b1101111) begin
            r.wen   = 1'b1;
            r.wdata = model_pc + 32'd4;
            next    = model_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == 7'b1100111 && w[14:12] == 3'd0) begin
            r.wen   = 1'b1;
            r.wdata = model_pc + 32'd4;
            next    = (a + imm_i) & ~32'd1;     // target bit 0 cleared
        end else if (w[6:0] == 7'b0110111) begin
            r.wen   = 1'b1;
            r.wdata = {w[31:12], 12'd0};
        end else if (w[6:0] == 7'b0010111) begin
            r.wen   = 1'b1;
            r.wdata = model_pc + {w[31:12], 12'd0};
        end else begin
            model_halted  = 1'b1;
            model_illegal = 1'b1;
        end
        if (r.wen && rd != 5'd0) begin
            model_regs[rd] = r.wdata;
        end
        model_pc = next;
        return r;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        logic bad;
        bad = (act.valid !== exp.valid) || (act.pc !== exp.pc) || (act.wen !== exp.wen);
        if (exp.wen) begin
            bad = bad || (act.rd !== exp.rd) || (act.wdata !== exp.wdata);
        end
        if (bad) begin
            stop_on_error($sformatf(
                "Fail %s: expected pc=%h rd=%0d wen=%b wdata=%h, actual pc=%h rd=%0d wen=%b wdata=%h",
                name, exp.pc, exp.rd, exp.wen, exp.wdata, act.pc, act.rd, act.wen, act.wdata));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("Fail %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = itype_word(12'(i), 5'd0, 5'd0, 7'b0010011);   // addi x0, x0, index
        end
    endtask

    task automatic load_main_program();
        fill_memory();
        mem[0]  = itype_word(12'd5, 5'd0, 5'd1, OP_I);
        mem[1]  = itype_word(12'd5, 5'd0, 5'd2, OP_I);
        mem[2]  = btype_word(13'd8, 5'd2, 5'd1);                  // equal, falls through
        mem[3]  = itype_word(12'hff9, 5'd0, 5'd3, OP_I);
        mem[4]  = btype_word(13'd8, 5'd3, 5'd1);                  // skips word 5
        mem[5]  = itype_word(12'd99, 5'd0, 5'd4, OP_I);
        mem[6]  = jtype_word(21'd20, 5'd5);                       // call word 11
        mem[7]  = rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0);      // add into x0
        mem[8]  = rtype_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd9);      // reads x0
        mem[9]  = jtype_word(21'd16, 5'd0);                       // on to word 13
        mem[11] = itype_word(12'd1, 5'd5, 5'd6, OP_I);            // odd return address
        mem[12] = itype_word(12'd0, 5'd6, 5'd10, OP_JALR);
        for (int k = 13; k < 53; k++) begin
            case (rand_bits(3) % 5)
                0: mem[k] = rtype_word(7'h00, 5'(rand_bits(4)), 5'(rand_bits(4)), 3'd0,
                                       5'(rand_bits(4)));
                1: mem[k] = rtype_word(7'h20, 5'(rand_bits(4)), 5'(rand_bits(4)), 3'd0,
                                       5'(rand_bits(4)));
                2: mem[k] = itype_word(12'(rand_bits(12)), 5'(rand_bits(4)),
                                       5'(rand_bits(4)), OP_I);
                3: mem[k] = {20'(rand_bits(20)), 5'(rand_bits(4)), 7'(OP_LUI)};
                default: mem[k] = {20'(rand_bits(20)), 5'(rand_bits(4)), 7'(OP_AUIPC)};
            endcase
        end
        mem[53] = `RVSEED_EBREAK_WORD;
    endtask

    task automatic load_illegal_program();
        fill_memory();
        mem[0] = itype_word(12'd3, 5'd0, 5'd1, OP_I);
        mem[1] = itype_word(12'd4, 5'd0, 5'd2, OP_I);
        mem[2] = rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
        mem[3] = rtype_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd4);     // sll, not supported
        mem[4] = `RVSEED_EBREAK_WORD;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        model_pc      = `RVSEED_RESET_PC;
        model_halted  = 1'b0;
        model_illegal = 1'b0;
        retired       = 0;
        for (int i = 0; i < `RVSEED_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_halt(input int limit);
        for (int n = 0; !model_halted; n++) begin
            if (n >= limit) begin
                stop_on_error($sformatf("%s run: the core did not reach its halt in time",
                                        run_name));
            end
            @(negedge clk);
        end
    endtask

    // wishbone slave with 0 to 3 wait states
    always @(posedge clk) begin
        if (reset) begin
            wb_ack  <= 1'b0;
            serving = 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!serving) begin
                check_flag("wb_we", 1'b0, wb_we);           // fetch is read only
                check_sel("wb_sel", 4'hf, wb_sel);
                serving   = 1'b1;
                wait_left = int'(rand_bits(2));
            end
            if (wait_left == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= mem[wb_adr[9:2]];
                serving  = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // compare every retire record against the model
    always @(negedge clk) begin
        if (i_dut.i_sva.fail_count != 0) begin
            stop_on_error("a bound Wishbone or retire assertion failed");
        end else if (!reset && retire.valid) begin
            if (model_halted) begin
                stop_on_error("a retire record appeared after the halting instruction");
            end else begin
                expected_rec = model_step(mem[model_pc[9:2]]);
                check_retire($sformatf("%s retire %0d", run_name, retired), expected_rec, retire);
                retired++;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        wb_ack     = 1'b0;
        wb_dat_i   = '0;
        serving    = 1'b0;
        wait_left  = 0;
        lfsr_state = 32'h9666;
        run_name   = "main";
        model_halted = 1'b0;

        load_main_program();
        apply_reset();
        wait_for_halt(4000);
        check_flag("main halt", model_halted, halt);
        check_flag("main illegal", model_illegal, illegal);
        check_count("main retire count", 52, retired);
        repeat (50) begin
            @(negedge clk);
            if (wb_stb || wb_cyc) begin
                stop_on_error("a Wishbone cycle started after the core halted on ebreak");
            end
        end

        run_name = "illegal";
        load_illegal_program();
        apply_reset();
        @(negedge clk);
        check_flag("illegal run halt after reset", 1'b0, halt);
        check_flag("illegal run illegal after reset", 1'b0, illegal);
        wait_for_halt(400);
        check_flag("illegal halt", model_halted, halt);
        check_flag("illegal flag", model_illegal, illegal);
        check_count("illegal retire count", 4, retired);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/rvseed_pkg.sv
src/ctrl.sv
src/imm_gen.sv
src/regfile.sv
src/exec_unit.sv
src/fetch_wb.sv
src/rvseed_core.sv
testbench/rvseed_sva.sv
testbench/tb_rvseed.sv
